// ==== leaf_i4o5.f ====
+incdir+.
leaf_pkg.sv
stream_fifo.sv
leaf_rx_demux.sv
leaf_tx_arbiter.sv
leaf_interface.sv
user_kernel.sv
leaf_i4o5.sv
tb_clock_gen.sv
leaf_tb.sv

// ==== Makefile ====
SIM       = verilator
SIM_FLAGS = --binary --timing --assert -Wno-fatal -j 0
TOP       = leaf_tb
FILE_LIST = leaf_i4o5.f
BUILD_DIR = obj_dir

.PHONY: sim clean

sim:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== leaf_tb.sv ====
`timescale 1ns/1ps
`include "leaf_config.svh"

module leaf_tb import leaf_pkg::*; ();

    localparam int NO            = `LEAF_NUM_OUT_PORTS;
    localparam int CLK_PERIOD_NS = 4;
    localparam int DRIVE_DELAY   = 1;
    localparam int NUM_PACKETS   = 600;
    localparam int DRAIN_CYCLES  = 400;
    localparam int WATCHDOG_NS   = NUM_PACKETS * 40 * CLK_PERIOD_NS + 2000;

    logic        clk;
    logic        rst;
    logic        resend;
    packet_t     din;
    packet_t     dout;
    logic [31:0] lcg_state;
    logic        idle_phase;
    int          rs_left;
    int          gap_left;
    route_t      model_route [NO];
    logic [`LEAF_NUM_ADDR_BITS-1:0] exp_seq [NO];
    user_word_t  exp_q [NO][$];

    tb_clock_gen #(.PERIOD_NS(CLK_PERIOD_NS)) clock_gen_inst (.clk(clk));

    leaf_i4o5 leaf_i4o5_inst (
        .clk                     (clk),
        .rst                     (rst),
        .din_leaf_bft2interface  (din),
        .dout_leaf_interface2bft (dout),
        .resend                  (resend)
    );

    // ======================================================================
    // helpers.
    // ======================================================================
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped on error.");
    endtask

    task automatic check_packet(input string name, input packet_t got, input packet_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail at %t: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_word(input string name, input user_word_t got, input user_word_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail at %t: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_route(input string name, input route_t got, input route_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail at %t: %s got leaf %0d port %0d expected leaf %0d port %0d",
                                $time, name, got.leaf, got.port, exp.leaf, exp.port));
        end
    endtask

    // lcg, upper bits are the useful ones.
    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // 40% to port 1, which also feeds output 5, and 10% to unused ports.
    function automatic int pick_port();
        int sel;
        sel = int'((next_random() >> 16) % 10);
        if (sel < 4) begin
            return 1;
        end else if (sel < 9) begin
            return 2 + (sel - 4) / 2;
        end else begin
            return 5 + int'((next_random() >> 16) % 11);
        end
    endfunction

    function automatic packet_t make_config(input int out_port, input route_t r);
        packet_t p;
        p.vld            = 1'b1;
        p.leaf           = `LEAF_ID;
        p.port           = '0;
        p.seq            = 7'(next_random() >> 25);
        p.payload        = next_random();
        p.payload[2:0]   = 3'(out_port);
        p.payload[11:8]  = r.port;
        p.payload[20:16] = r.leaf;
        return p;
    endfunction

    function automatic packet_t make_data(input int k, input user_word_t w);
        packet_t p;
        p.vld     = 1'b1;
        p.leaf    = `LEAF_ID;
        p.port    = 4'(k);
        p.seq     = 7'(next_random() >> 25);
        p.payload = w;
        return p;
    endfunction

    // vld low, the other fields are noise.
    function automatic packet_t idle_noise();
        packet_t p;
        p         = '0;
        p.port    = 4'(next_random() >> 28);
        p.payload = next_random();
        return p;
    endfunction

    function automatic bit queues_empty();
        int j;
        for (j = 0; j < NO; j++) begin
            if (exp_q[j].size() != 0) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #(DRIVE_DELAY);
    endtask

    task automatic expect_data(input int k, input user_word_t w);
        exp_q[k-1].push_back(w + user_word_t'(k));
        if (k == 1) begin
            exp_q[NO-1].push_back((w << 8) | (w >> 24));
        end
    endtask

    task automatic step_resend();
        if (rs_left > 0) begin
            rs_left--;
            resend = 1'b1;
        end else begin
            resend = 1'b0;
            if (gap_left > 0) begin
                gap_left--;
            end else begin
                rs_left  = 4 + int'((next_random() >> 16) % 32);
                gap_left = 20 + int'((next_random() >> 16) % 64);
            end
        end
    endtask

    task automatic match_output(input packet_t got);
        int      j;
        int      i;
        packet_t exp;
        j = -1;
        for (i = 0; i < NO; i++) begin
            if (model_route[i].port == got.port) begin
                j = i;
            end
        end
        if (j < 0) begin
            abort_run($sformatf("packet at %t goes to port %0d, which no route uses.",
                                $time, got.port));
        end
        if (exp_q[j].size() == 0) begin
            abort_run($sformatf("output port %0d sent a packet at %t that was not expected.",
                                j + 1, $time));
        end
        check_route($sformatf("route of output port %0d", j + 1),
                    '{leaf: got.leaf, port: got.port}, model_route[j]);
        check_word($sformatf("payload of output port %0d", j + 1), got.payload, exp_q[j][0]);
        exp = '{vld: 1'b1, leaf: model_route[j].leaf, port: model_route[j].port,
                seq: exp_seq[j], payload: exp_q[j][0]};
        check_packet("dout_leaf_interface2bft", got, exp);
        void'(exp_q[j].pop_front());
        exp_seq[j] = exp_seq[j] + 1'b1;
    endtask

    // ======================================================================
    // stimulus.
    // ======================================================================
    initial begin
        int         base;
        int         j;
        int         n;
        int         k;
        int         drain;
        user_word_t w;
        $timeformat(-9, 0, " ns", 0);
        lcg_state  = 32'ha613_fbd7;
        rst        = 1'b1;
        resend     = 1'b0;
        din        = '0;
        idle_phase = 1'b1;
        rs_left    = 0;
        gap_left   = 30;
        for (j = 0; j < NO; j++) begin
            exp_seq[j] = '0;
        end
        repeat (8) @(posedge clk);
        #(DRIVE_DELAY);
        rst = 1'b0;

        // five routes, destination ports kept distinct.
        base = int'((next_random() >> 16) % 16);
        for (j = 0; j < NO; j++) begin
            model_route[j].port = 4'((base + 3 * j) % 16);
            model_route[j].leaf = 5'(next_random() >> 27);
        end
        for (j = 0; j < NO; j++) begin
            next_cycle();
            din = make_config(j + 1, model_route[j]);
            next_cycle();
            din = idle_noise();
        end
        repeat (10) next_cycle();

        // one packet every 4 cycles, random resend windows.
        idle_phase = 1'b0;
        for (n = 0; n < NUM_PACKETS; n++) begin
            next_cycle();
            step_resend();
            k   = pick_port();
            w   = next_random();
            din = make_data(k, w);
            if (k <= `LEAF_NUM_IN_PORTS) begin
                expect_data(k, w);
            end
            repeat (3) begin
                next_cycle();
                step_resend();
                din = idle_noise();
            end
        end
        next_cycle();
        din    = '0;
        resend = 1'b0;
        drain  = 0;
        while (!queues_empty() && drain < DRAIN_CYCLES) begin
            next_cycle();
            drain++;
        end
        // quiet time, a duplicate would show here.
        repeat (40) next_cycle();

        if (queues_empty()) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            abort_run("model queues still hold expected packets at the end.");
        end
    end

    // ======================================================================
    // output monitor, sampled mid cycle.
    // ======================================================================
    initial begin
        @(posedge clk);
        forever begin
            @(negedge clk);
            if (rst || idle_phase || resend || !dout.vld) begin
                check_packet("dout_leaf_interface2bft", dout, '0);
            end else begin
                match_output(dout);
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        abort_run("watchdog expired before every expected packet came out.");
    end

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 4
) (
    output logic clk
);

    // free running, first rising edge half a period in.
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0) clk = ~clk;
        end
    end

endmodule

// ==== leaf_i4o5.sv ====
`timescale 1ns/1ps
`include "leaf_config.svh"

module leaf_i4o5 import leaf_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  packet_t din_leaf_bft2interface,
    output packet_t dout_leaf_interface2bft,
    input  logic    resend
);

    user_bus_t [`LEAF_NUM_IN_PORTS-1:0]  bus_interface2user;
    logic [`LEAF_NUM_IN_PORTS-1:0]       ack_user2interface;
    user_bus_t [`LEAF_NUM_OUT_PORTS-1:0] bus_user2interface;
    logic [`LEAF_NUM_OUT_PORTS-1:0]      ack_interface2user;

    leaf_interface leaf_interface_inst (
        .clk                     (clk),
        .rst                     (rst),
        .resend                  (resend),
        .din_leaf_bft2interface  (din_leaf_bft2interface),
        .dout_leaf_interface2bft (dout_leaf_interface2bft),
        .bus_interface2user      (bus_interface2user),
        .ack_user2interface      (ack_user2interface),
        .bus_user2interface      (bus_user2interface),
        .ack_interface2user      (ack_interface2user)
    );

    // example kernel in place of the user region.
    user_kernel user_kernel_inst (
        .clk     (clk),
        .rst     (rst),
        .in_bus  (bus_interface2user),
        .in_ack  (ack_user2interface),
        .out_bus (bus_user2interface),
        .out_ack (ack_interface2user)
    );

endmodule

// ==== user_kernel.sv ====
`timescale 1ns/1ps
`include "leaf_config.svh"

module user_kernel import leaf_pkg::*; (
    input  logic                                clk,
    input  logic                                rst,
    input  user_bus_t [`LEAF_NUM_IN_PORTS-1:0]  in_bus,
    output logic [`LEAF_NUM_IN_PORTS-1:0]       in_ack,
    output user_bus_t [`LEAF_NUM_OUT_PORTS-1:0] out_bus,
    input  logic [`LEAF_NUM_OUT_PORTS-1:0]      out_ack
);

    localparam int NI = `LEAF_NUM_IN_PORTS;
    localparam int NO = `LEAF_NUM_OUT_PORTS;
    localparam int W  = `LEAF_PAYLOAD_BITS;

    logic          out_vld  [NO];
    user_word_t    out_data [NO];
    logic [NO-1:0] out_free;
    logic [NI-1:0] take;

    // a result register can load when empty or when it drains this cycle.
    for (genvar k = 0; k < NO; k++) begin : g_free
        assign out_free[k] = ~out_vld[k] | out_ack[k];
        assign out_bus[k]  = '{vld: out_vld[k], data: out_data[k]};
    end

    always_comb begin
        in_ack = out_free[NI-1:0];
        // input 1 feeds port 5 too.
        in_ack[0] = out_free[0] & out_free[NO-1];
    end

    // ======================================================================
    // result registers.
    // ======================================================================
    for (genvar k = 0; k < NO; k++) begin : g_lane
        localparam int SRC = (k < NI) ? k : 0;

        if (k < NI) begin : g_take
            assign take[k] = in_bus[k].vld & in_ack[k];
        end

        always_ff @(posedge clk) begin
            if (rst) begin
                out_vld[k] <= 1'b0;
            end else if (take[SRC]) begin
                out_vld[k] <= 1'b1;
            end else if (out_ack[k]) begin
                out_vld[k] <= 1'b0;
            end
        end

        always_ff @(posedge clk) begin
            if (take[SRC]) begin
                if (k < NI) begin
                    out_data[k] <= in_bus[SRC].data + user_word_t'(k + 1);
                end else begin
                    out_data[k] <= {in_bus[SRC].data[W-9:0], in_bus[SRC].data[W-1:W-8]};
                end
            end
        end

        a_hold: assert property (@(posedge clk) disable iff (rst)
            out_vld[k] && !out_ack[k] |=> out_vld[k] && $stable(out_data[k]))
            else $error("user_kernel: output %0d dropped before ack.", k + 1);
    end

endmodule

// ==== leaf_interface.sv ====
`timescale 1ns/1ps
`include "leaf_config.svh"

module leaf_interface import leaf_pkg::*; (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                resend,
    input  packet_t                             din_leaf_bft2interface,
    output packet_t                             dout_leaf_interface2bft,
    output user_bus_t [`LEAF_NUM_IN_PORTS-1:0]  bus_interface2user,
    input  logic [`LEAF_NUM_IN_PORTS-1:0]       ack_user2interface,
    input  user_bus_t [`LEAF_NUM_OUT_PORTS-1:0] bus_user2interface,
    output logic [`LEAF_NUM_OUT_PORTS-1:0]      ack_interface2user
);

    localparam int NI = `LEAF_NUM_IN_PORTS;
    localparam int NO = `LEAF_NUM_OUT_PORTS;

    logic [NI-1:0]          in_wr_en;
    user_word_t             in_wr_data;
    logic [NI-1:0]          in_rd_en;
    logic [NI-1:0]          in_empty;
    user_word_t [NI-1:0]    in_data;
    route_t [NO-1:0]        route_table;
    logic [NO-1:0]          out_wr_en;
    logic [NO-1:0]          out_full;
    logic [NO-1:0]          q_rd_en;
    logic [NO-1:0]          q_empty;
    user_word_t [NO-1:0]    q_data;

    leaf_rx_demux rx_demux_inst (
        .clk         (clk),
        .rst         (rst),
        .din         (din_leaf_bft2interface),
        .in_wr_en    (in_wr_en),
        .in_wr_data  (in_wr_data),
        .route_table (route_table)
    );

    // ======================================================================
    // tree to kernel.
    // ======================================================================
    for (genvar k = 0; k < NI; k++) begin : g_in
        assign in_rd_en[k]           = ~in_empty[k] & ack_user2interface[k];
        assign bus_interface2user[k] = '{vld: ~in_empty[k], data: in_data[k]};

        // overflow is flagged inside the FIFO.
        stream_fifo #(.entry_t(user_word_t), .DEPTH(`LEAF_FIFO_DEPTH)) in_fifo_inst (
            .clk     (clk),
            .rst     (rst),
            .wr_en   (in_wr_en[k]),
            .wr_data (in_wr_data),
            .rd_en   (in_rd_en[k]),
            .rd_data (in_data[k]),
            .empty   (in_empty[k]),
            .full    ()
        );
    end

    // ======================================================================
    // kernel to tree.
    // ======================================================================
    for (genvar k = 0; k < NO; k++) begin : g_out
        assign ack_interface2user[k] = ~out_full[k];
        assign out_wr_en[k]          = bus_user2interface[k].vld & ~out_full[k];

        stream_fifo #(.entry_t(user_word_t), .DEPTH(`LEAF_FIFO_DEPTH)) out_fifo_inst (
            .clk     (clk),
            .rst     (rst),
            .wr_en   (out_wr_en[k]),
            .wr_data (bus_user2interface[k].data),
            .rd_en   (q_rd_en[k]),
            .rd_data (q_data[k]),
            .empty   (q_empty[k]),
            .full    (out_full[k])
        );
    end

    leaf_tx_arbiter tx_arbiter_inst (
        .clk         (clk),
        .rst         (rst),
        .resend      (resend),
        .q_empty     (q_empty),
        .q_data      (q_data),
        .route_table (route_table),
        .q_rd_en     (q_rd_en),
        .dout        (dout_leaf_interface2bft)
    );

endmodule

// ==== leaf_tx_arbiter.sv ====
`timescale 1ns/1ps
`include "leaf_config.svh"

module leaf_tx_arbiter import leaf_pkg::*; (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 resend,
    input  logic [`LEAF_NUM_OUT_PORTS-1:0]       q_empty,
    input  user_word_t [`LEAF_NUM_OUT_PORTS-1:0] q_data,
    input  route_t [`LEAF_NUM_OUT_PORTS-1:0]     route_table,
    output logic [`LEAF_NUM_OUT_PORTS-1:0]       q_rd_en,
    output packet_t                              dout
);

    localparam int NQ = `LEAF_NUM_OUT_PORTS;
    localparam int IW = $clog2(NQ);
    localparam int SW = `LEAF_NUM_ADDR_BITS;

    logic [IW-1:0] rr_ptr;
    logic [IW-1:0] win_idx;
    logic          win_vld;
    logic [SW-1:0] seq_cnt [NQ];
    packet_t       dout_q;

    // ======================================================================
    // round robin pick, first non-empty queue at or after rr_ptr.
    // ======================================================================
    always_comb begin
        int cand;
        win_idx = '0;
        win_vld = 1'b0;
        for (int i = 0; i < NQ; i++) begin
            cand = (int'(rr_ptr) + i) % NQ;
            if (!win_vld && !q_empty[cand]) begin
                win_vld = 1'b1;
                win_idx = IW'(cand);
            end
        end
    end

    // nothing is popped while the tree asks for a resend.
    always_comb begin
        q_rd_en = '0;
        if (win_vld && !resend) begin
            q_rd_en[win_idx] = 1'b1;
        end
    end

    // ======================================================================
    // packet register.
    // ======================================================================
    // held through resend, so the packet goes out once resend drops.
    always_ff @(posedge clk) begin
        if (rst) begin
            rr_ptr <= '0;
            dout_q <= '0;
            for (int i = 0; i < NQ; i++) begin
                seq_cnt[i] <= '0;
            end
        end else if (!resend) begin
            if (win_vld) begin
                dout_q.vld     <= 1'b1;
                dout_q.leaf    <= route_table[win_idx].leaf;
                dout_q.port    <= route_table[win_idx].port;
                dout_q.seq     <= seq_cnt[win_idx];
                dout_q.payload <= q_data[win_idx];
                seq_cnt[win_idx] <= seq_cnt[win_idx] + 1'b1;
                rr_ptr <= (win_idx == IW'(NQ - 1)) ? '0 : win_idx + 1'b1;
            end else begin
                dout_q <= '0;
            end
        end
    end

    assign dout = resend ? '0 : dout_q;

    // a queue just served yields to any other queue that holds data.
    for (genvar q = 0; q < NQ; q++) begin : g_fair
        a_rr_fair: assert property (@(posedge clk) disable iff (rst)
            $past(q_rd_en[q]) && |(~q_empty & ~(NQ'(1) << q)) |-> !q_rd_en[q])
            else $error("leaf_tx_arbiter: queue %0d served twice in a row.", q + 1);
    end

endmodule

// ==== leaf_rx_demux.sv ====
`timescale 1ns/1ps
`include "leaf_config.svh"

module leaf_rx_demux import leaf_pkg::*; (
    input  logic                                clk,
    input  logic                                rst,
    input  packet_t                             din,
    output logic [`LEAF_NUM_IN_PORTS-1:0]       in_wr_en,
    output user_word_t                          in_wr_data,
    output route_t [`LEAF_NUM_OUT_PORTS-1:0]    route_table
);

    localparam int NI = `LEAF_NUM_IN_PORTS;
    localparam int NO = `LEAF_NUM_OUT_PORTS;
    localparam int IW = $clog2(NI);

    packet_t       din_q;
    logic [2:0]    cfg_sel;
    logic [2:0]    cfg_idx;
    logic          cfg_we;
    logic [IW-1:0] in_idx;
    logic          data_hit;

    // ======================================================================
    // input register, the tree gives no back-pressure.
    // ======================================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            din_q <= '0;
        end else begin
            din_q <= din;
        end
    end

    // ======================================================================
    // decode by port field.
    // ======================================================================
    // port 0 is configuration, payload[2:0] picks output port 1..5.
    assign cfg_sel = din_q.payload[2:0];
    assign cfg_idx = cfg_sel - 3'd1;
    assign cfg_we  = din_q.vld && (din_q.port == '0) &&
                     (cfg_sel != 3'd0) && (cfg_sel <= 3'(NO));

    assign data_hit = din_q.vld && (din_q.port != '0) &&
                      (din_q.port <= `LEAF_NUM_PORT_BITS'(NI));
    assign in_idx   = IW'(din_q.port - 1'b1);

    always_comb begin
        in_wr_en = '0;
        if (data_hit) begin
            in_wr_en[in_idx] = 1'b1;
        end
    end

    assign in_wr_data = din_q.payload;

    // ======================================================================
    // routing table.
    // ======================================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            route_table <= '0;
        end else if (cfg_we) begin
            route_table[cfg_idx].leaf <= din_q.payload[16 +: `LEAF_NUM_LEAF_BITS];
            route_table[cfg_idx].port <= din_q.payload[8 +: `LEAF_NUM_PORT_BITS];
        end
    end

endmodule

// ==== stream_fifo.sv ====
`timescale 1ns/1ps
`include "leaf_config.svh"

module stream_fifo #(
    parameter type entry_t = logic [`LEAF_PAYLOAD_BITS-1:0],
    parameter int  DEPTH   = `LEAF_FIFO_DEPTH
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   wr_en,
    input  entry_t wr_data,
    input  logic   rd_en,
    output entry_t rd_data,
    output logic   empty,
    output logic   full
);

    localparam int AW = $clog2(DEPTH);
    localparam int CW = $clog2(DEPTH + 1);

    entry_t        mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          do_wr;
    logic          do_rd;

    assign empty = (count == '0);
    assign full  = (count == CW'(DEPTH));
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    // head of the queue is always visible.
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (rst) !(wr_en && full))
        else $error("stream_fifo: write while full.");
    a_no_underflow: assert property (@(posedge clk) disable iff (rst) !(rd_en && empty))
        else $error("stream_fifo: read while empty.");

endmodule

// ==== leaf_pkg.sv ====
`include "leaf_config.svh"

package leaf_pkg;

    // one word on the user side.
    typedef logic [`LEAF_PAYLOAD_BITS-1:0] user_word_t;

    // tree packet, vld in the top bit.
    typedef struct packed {
        logic                           vld;
        logic [`LEAF_NUM_LEAF_BITS-1:0] leaf;
        logic [`LEAF_NUM_PORT_BITS-1:0] port;
        logic [`LEAF_NUM_ADDR_BITS-1:0] seq;
        user_word_t                     payload;
    } packet_t;

    // where one output port sends its packets.
    typedef struct packed {
        logic [`LEAF_NUM_LEAF_BITS-1:0] leaf;
        logic [`LEAF_NUM_PORT_BITS-1:0] port;
    } route_t;

    // forward half of a vld/ack channel.
    typedef struct packed {
        logic       vld;
        user_word_t data;
    } user_bus_t;

endpackage

// ==== leaf_config.svh ====
`ifndef LEAF_CONFIG_SVH
`define LEAF_CONFIG_SVH

// ==========================================================================
// tree packet format.
// ==========================================================================
`define LEAF_PACKET_BITS   49
`define LEAF_PAYLOAD_BITS  32
`define LEAF_NUM_LEAF_BITS 5
`define LEAF_NUM_PORT_BITS 4
`define LEAF_NUM_ADDR_BITS 7

// ==========================================================================
// user side and buffering.
// ==========================================================================
`define LEAF_NUM_IN_PORTS  4
`define LEAF_NUM_OUT_PORTS 5
`define LEAF_FIFO_DEPTH    16
// address of this leaf in the tree.
`define LEAF_ID            5'd2

`endif
